// File: src/axis_types_pkg.sv
package axis_types_pkg;

    // payload and sideband widths of every stream link.
    localparam int data_w = 16;
    localparam int keep_w = data_w / 8;
    localparam int dest_w = 4;
    localparam int user_w = 1;

    // a stored beat holds data, keep, last, dest and user, in that order from the msb.
    localparam int beat_w = data_w + keep_w + 1 + dest_w + user_w;

    typedef logic [data_w-1:0] axis_data_t;

    // one enable bit per payload byte.
    typedef logic [keep_w-1:0] axis_keep_t;

    typedef logic [dest_w-1:0] axis_dest_t;

    // a 1 on the last beat of a frame marks the frame as bad.
    typedef logic [user_w-1:0] axis_user_t;

    typedef logic [beat_w-1:0] axis_beat_t;

endpackage

// File: src/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

    // default number of entries in the shift-register FIFO.
    localparam int fifo_depth = 16;

    // occupancy runs from 0 to fifo_depth inclusive.
    localparam int fifo_count_w = $clog2(fifo_depth + 1);

    typedef logic [fifo_count_w-1:0] fifo_count_t;

    // statistics counters wrap at 32 bits.
    localparam int stat_count_w = 32;

    typedef logic [stat_count_w-1:0] stat_count_t;

endpackage

// File: src/axis_skid_buffer.sv
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  axis_types_pkg::axis_data_t s_tdata,
    input  axis_types_pkg::axis_keep_t s_tkeep,
    input  logic                       s_tlast,
    input  axis_types_pkg::axis_dest_t s_tdest,
    input  axis_types_pkg::axis_user_t s_tuser,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    output axis_types_pkg::axis_data_t m_tdata,
    output axis_types_pkg::axis_keep_t m_tkeep,
    output logic                       m_tlast,
    output axis_types_pkg::axis_dest_t m_tdest,
    output axis_types_pkg::axis_user_t m_tuser,
    output logic                       m_tvalid,
    input  logic                       m_tready
);
    import axis_types_pkg::*;

    axis_beat_t s_beat;
    axis_beat_t out_beat;
    axis_beat_t spill_beat;
    logic       out_valid;
    logic       spill_valid;
    logic       ready_reg;
    logic       s_fire;
    logic       out_free;

    assign s_beat = {s_tdata, s_tkeep, s_tlast, s_tdest, s_tuser};
    assign s_fire = s_tvalid && ready_reg;

    // the output slot can take a new beat when it is empty or its beat leaves now.
    assign out_free = m_tready || !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spill_valid <= 1'b0;
            ready_reg   <= 1'b1;
        end else if (out_free) begin
            if (spill_valid) begin
                out_valid   <= 1'b1;
                spill_valid <= 1'b0;
                ready_reg   <= 1'b1;
            end else begin
                out_valid <= s_fire;
            end
        end else if (s_fire) begin
            // output is stalled, so the arriving beat parks in the spill slot.
            spill_valid <= 1'b1;
            ready_reg   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (spill_valid) begin
                out_beat <= spill_beat;
            end else if (s_fire) begin
                out_beat <= s_beat;
            end
        end else if (s_fire) begin
            spill_beat <= s_beat;
        end
    end

    assign s_tready = ready_reg;
    assign m_tvalid = out_valid;
    assign {m_tdata, m_tkeep, m_tlast, m_tdest, m_tuser} = out_beat;

endmodule

// File: src/axis_srl_fifo.sv
`timescale 1ns/1ps

module axis_srl_fifo #(
    parameter int depth = fifo_cfg_pkg::fifo_depth
) (
    input  logic                       clk,
    input  logic                       rst,
    input  axis_types_pkg::axis_data_t s_tdata,
    input  axis_types_pkg::axis_keep_t s_tkeep,
    input  logic                       s_tlast,
    input  axis_types_pkg::axis_dest_t s_tdest,
    input  axis_types_pkg::axis_user_t s_tuser,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    output axis_types_pkg::axis_data_t m_tdata,
    output axis_types_pkg::axis_keep_t m_tkeep,
    output logic                       m_tlast,
    output axis_types_pkg::axis_dest_t m_tdest,
    output axis_types_pkg::axis_user_t m_tuser,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output fifo_cfg_pkg::fifo_count_t  count
);
    import axis_types_pkg::*;
    import fifo_cfg_pkg::*;

    // the index into the shift array keeps one bit even for a single entry.
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    axis_beat_t  data_reg [depth];
    axis_beat_t  s_beat;
    axis_beat_t  m_beat;
    fifo_count_t ptr_reg;
    fifo_count_t rd_idx;
    logic        full_reg;
    logic        full_next;
    logic        empty_reg;
    logic        empty_next;
    logic        ptr_empty1;
    logic        ptr_full1;
    logic        shift;
    logic        inc;
    logic        dec;

    assign s_beat = {s_tdata, s_tkeep, s_tlast, s_tdest, s_tuser};

    // the oldest beat sits one below the pointer.
    assign rd_idx = ptr_reg - 1'b1;
    assign m_beat = data_reg[rd_idx[idx_w-1:0]];

    assign s_tready = !full_reg;
    assign m_tvalid = !empty_reg;
    assign {m_tdata, m_tkeep, m_tlast, m_tdest, m_tuser} = m_beat;
    assign count = ptr_reg;

    assign ptr_empty1 = (ptr_reg == fifo_count_t'(1));
    assign ptr_full1  = (ptr_reg == fifo_count_t'(depth - 1));

    always_comb begin
        shift      = 1'b0;
        inc        = 1'b0;
        dec        = 1'b0;
        full_next  = full_reg;
        empty_next = empty_reg;

        if (m_tready && s_tvalid && s_tready) begin
            // with the output ready a write and a read cancel out unless the FIFO is empty.
            shift      = 1'b1;
            inc        = empty_reg;
            empty_next = 1'b0;
        end else if (m_tready && m_tvalid) begin
            dec        = 1'b1;
            full_next  = 1'b0;
            empty_next = ptr_empty1;
        end else if (s_tvalid && s_tready) begin
            shift      = 1'b1;
            inc        = 1'b1;
            full_next  = ptr_full1;
            empty_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_reg   <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
        end else begin
            if (inc) begin
                ptr_reg <= ptr_reg + 1'b1;
            end else if (dec) begin
                ptr_reg <= ptr_reg - 1'b1;
            end
            full_reg  <= full_next;
            empty_reg <= empty_next;
        end
    end

    // every accepted beat enters at entry 0 and pushes the rest up by one.
    always_ff @(posedge clk) begin
        if (shift) begin
            data_reg[0] <= s_beat;
            for (int i = 0; i < depth - 1; i++) begin
                data_reg[i+1] <= data_reg[i];
            end
        end
    end

endmodule

// File: src/axis_frame_monitor.sv
`timescale 1ns/1ps

module axis_frame_monitor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       tvalid,
    input  logic                       tready,
    input  logic                       tlast,
    input  axis_types_pkg::axis_keep_t tkeep,
    input  axis_types_pkg::axis_user_t tuser,
    output fifo_cfg_pkg::stat_count_t  frame_count,
    output fifo_cfg_pkg::stat_count_t  byte_count,
    output fifo_cfg_pkg::stat_count_t  bad_frame_count
);
    import axis_types_pkg::*;
    import fifo_cfg_pkg::*;

    logic        fire;
    stat_count_t beat_bytes;

    assign fire = tvalid && tready;

    // number of valid bytes in the current beat.
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < keep_w; i++) begin
            beat_bytes = beat_bytes + stat_count_t'(tkeep[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count     <= '0;
            byte_count      <= '0;
            bad_frame_count <= '0;
        end else if (fire) begin
            byte_count <= byte_count + beat_bytes;
            if (tlast) begin
                frame_count <= frame_count + 1'b1;
                // tuser is only meaningful on the closing beat.
                if (tuser[0]) begin
                    bad_frame_count <= bad_frame_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/axis_buffered_path.sv
`timescale 1ns/1ps

module axis_buffered_path (
    input  logic                       clk,
    input  logic                       rst,
    input  axis_types_pkg::axis_data_t s_tdata,
    input  axis_types_pkg::axis_keep_t s_tkeep,
    input  logic                       s_tlast,
    input  axis_types_pkg::axis_dest_t s_tdest,
    input  axis_types_pkg::axis_user_t s_tuser,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    output axis_types_pkg::axis_data_t m_tdata,
    output axis_types_pkg::axis_keep_t m_tkeep,
    output logic                       m_tlast,
    output axis_types_pkg::axis_dest_t m_tdest,
    output axis_types_pkg::axis_user_t m_tuser,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output fifo_cfg_pkg::fifo_count_t  count,
    output fifo_cfg_pkg::stat_count_t  frame_count,
    output fifo_cfg_pkg::stat_count_t  byte_count,
    output fifo_cfg_pkg::stat_count_t  bad_frame_count
);
    import axis_types_pkg::*;
    import fifo_cfg_pkg::*;

    // link between the skid buffer and the FIFO.
    axis_data_t mid_tdata;
    axis_keep_t mid_tkeep;
    logic       mid_tlast;
    axis_dest_t mid_tdest;
    axis_user_t mid_tuser;
    logic       mid_tvalid;
    logic       mid_tready;

    axis_skid_buffer u_skid (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tdest  (s_tdest),
        .s_tuser  (s_tuser),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (mid_tdata),
        .m_tkeep  (mid_tkeep),
        .m_tlast  (mid_tlast),
        .m_tdest  (mid_tdest),
        .m_tuser  (mid_tuser),
        .m_tvalid (mid_tvalid),
        .m_tready (mid_tready)
    );

    axis_srl_fifo #(
        .depth (fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (mid_tdata),
        .s_tkeep  (mid_tkeep),
        .s_tlast  (mid_tlast),
        .s_tdest  (mid_tdest),
        .s_tuser  (mid_tuser),
        .s_tvalid (mid_tvalid),
        .s_tready (mid_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tdest  (m_tdest),
        .m_tuser  (m_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .count    (count)
    );

    // the monitor only observes the output link.
    axis_frame_monitor u_monitor (
        .clk             (clk),
        .rst             (rst),
        .tvalid          (m_tvalid),
        .tready          (m_tready),
        .tlast           (m_tlast),
        .tkeep           (m_tkeep),
        .tuser           (m_tuser),
        .frame_count     (frame_count),
        .byte_count      (byte_count),
        .bad_frame_count (bad_frame_count)
    );

endmodule

// File: test/axis_buffered_path_checker.sv
`timescale 1ns/1ps

module axis_buffered_path_checker (
    input logic                       clk,
    input logic                       rst,
    input axis_types_pkg::axis_data_t m_tdata,
    input axis_types_pkg::axis_keep_t m_tkeep,
    input logic                       m_tlast,
    input axis_types_pkg::axis_dest_t m_tdest,
    input axis_types_pkg::axis_user_t m_tuser,
    input logic                       m_tvalid,
    input logic                       m_tready,
    input logic                       fifo_s_tready,
    input fifo_cfg_pkg::fifo_count_t  count
);
    import fifo_cfg_pkg::*;

    assert property (@(posedge clk) rst |=> !m_tvalid)
        else $error("m_tvalid is high in the cycle after reset");

    // a stalled output beat has to stay put until the sink takes it.
    assert property (@(posedge clk) disable iff (rst)
        (m_tvalid && !m_tready) |=>
            (m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_tdest, m_tuser})))
        else $error("output beat changed while stalled");

    assert property (@(posedge clk) disable iff (rst) count <= fifo_count_t'(fifo_depth))
        else $error("FIFO count exceeds the depth");

    assert property (@(posedge clk) disable iff (rst)
        !fifo_s_tready == (count == fifo_count_t'(fifo_depth)))
        else $error("FIFO ready does not match its full state");

endmodule

bind axis_buffered_path axis_buffered_path_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .m_tdata       (m_tdata),
    .m_tkeep       (m_tkeep),
    .m_tlast       (m_tlast),
    .m_tdest       (m_tdest),
    .m_tuser       (m_tuser),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .fifo_s_tready (mid_tready),
    .count         (count)
);

// File: test/axis_buffered_path_tb.sv
`timescale 1ns/1ps

module axis_buffered_path_tb;
    import axis_types_pkg::*;
    import fifo_cfg_pkg::*;

    localparam int beat_total = 400;
    // twenty cycles per beat covers a 30 % acceptance rate with long stalls several times over.
    localparam int max_cycles = beat_total * 20;

    typedef struct packed {
        axis_data_t data;
        axis_keep_t keep;
        logic       last;
        axis_dest_t dest;
        axis_user_t user;
    } beat_t;

    logic        clk;
    logic        rst;
    axis_data_t  s_tdata;
    axis_keep_t  s_tkeep;
    logic        s_tlast;
    axis_dest_t  s_tdest;
    axis_user_t  s_tuser;
    logic        s_tvalid;
    logic        s_tready;
    axis_data_t  m_tdata;
    axis_keep_t  m_tkeep;
    logic        m_tlast;
    axis_dest_t  m_tdest;
    axis_user_t  m_tuser;
    logic        m_tvalid;
    logic        m_tready;
    fifo_count_t count;
    stat_count_t frame_count;
    stat_count_t byte_count;
    stat_count_t bad_frame_count;

    beat_t       model_q[$];
    logic [31:0] lcg_state = 32'h1974_afe3;
    int          cycle_count = 0;
    int          sent = 0;
    int          frame_left = 0;
    // the first output phase is a long stall so the FIFO is sure to fill.
    int          phase_left = 60;
    int          ready_mode = 2;
    logic        pending = 1'b0;
    logic        in_ready;
    logic        saw_full = 1'b0;
    logic        saw_stall = 1'b0;
    stat_count_t exp_frames = '0;
    stat_count_t exp_bytes = '0;
    stat_count_t exp_bad = '0;

    axis_buffered_path dut (.*);

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            fail_run("a DUT output did not match the model");
        end
    endtask

    task automatic drive_source();
        logic [31:0] r;
        r = next_random();
        if (pending) begin
            // a beat already offered stays unchanged until it is taken.
            s_tvalid = 1'b1;
        end else if (sent < beat_total && r[31:24] < 8'd179) begin
            if (frame_left == 0) begin
                frame_left = 1 + int'(r[18:16]);
            end
            s_tlast  = (frame_left == 1) || (sent == beat_total - 1);
            s_tdata  = axis_data_t'(next_random() >> 16);
            s_tdest  = axis_dest_t'(next_random() >> 28);
            s_tkeep  = (s_tlast && r[20]) ? 2'b01 : 2'b11;
            s_tuser  = s_tlast ? axis_user_t'(r[21]) : '0;
            s_tvalid = 1'b1;
            frame_left--;
        end else begin
            s_tvalid = 1'b0;
        end
    endtask

    task automatic drive_sink();
        logic [31:0] r;
        r = next_random();
        if (phase_left == 0) begin
            ready_mode = int'(r[31:30]);
            phase_left = (ready_mode == 2) ? 30 + int'(r[23:18]) : 8 + int'(r[23:18]);
        end
        phase_left--;
        if (sent >= beat_total) begin
            m_tready = 1'b1;
        end else if (ready_mode == 1) begin
            m_tready = r[15];
        end else begin
            m_tready = (ready_mode != 2);
        end
    endtask

    task automatic check_output();
        beat_t expected_beat;
        if (model_q.size() == 0) begin
            fail_run("an output beat arrived that was never sent");
        end else begin
            expected_beat = model_q.pop_front();
            check_value("m_tdata", 32'(expected_beat.data), 32'(m_tdata));
            check_value("m_tkeep", 32'(expected_beat.keep), 32'(m_tkeep));
            check_value("m_tlast", 32'(expected_beat.last), 32'(m_tlast));
            check_value("m_tdest", 32'(expected_beat.dest), 32'(m_tdest));
            check_value("m_tuser", 32'(expected_beat.user), 32'(m_tuser));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            fail_run("timeout: the stream did not finish within the cycle limit");
        end
    end

    initial begin
        rst      = 1'b1;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tdest  = '0;
        s_tuser  = '0;
        s_tvalid = 1'b0;
        m_tready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("m_tvalid", 32'd0, 32'(m_tvalid));
        check_value("s_tready", 32'd1, 32'(s_tready));
        check_value("count", 32'd0, 32'(count));
        check_value("frame_count", 32'd0, frame_count);
        check_value("byte_count", 32'd0, byte_count);
        check_value("bad_frame_count", 32'd0, bad_frame_count);

        while (sent < beat_total || model_q.size() != 0) begin
            @(negedge clk);
            // registered outputs are sampled before this cycle's inputs change.
            in_ready = s_tready;
            if (!in_ready) begin
                saw_stall = 1'b1;
            end
            if (count == fifo_count_t'(fifo_depth)) begin
                saw_full = 1'b1;
            end
            drive_source();
            drive_sink();
            if (s_tvalid && in_ready) begin
                model_q.push_back({s_tdata, s_tkeep, s_tlast, s_tdest, s_tuser});
                exp_bytes = exp_bytes + stat_count_t'($countones(s_tkeep));
                if (s_tlast) begin
                    exp_frames++;
                    if (s_tuser[0]) begin
                        exp_bad++;
                    end
                end
                sent++;
                pending = 1'b0;
            end else begin
                pending = s_tvalid;
            end
            if (m_tvalid && m_tready) begin
                check_output();
            end
        end

        // the last transfer and its counter update land on the next edge.
        repeat (2) @(negedge clk);
        check_value("count", 32'd0, 32'(count));
        check_value("m_tvalid", 32'd0, 32'(m_tvalid));
        check_value("frame_count", exp_frames, frame_count);
        check_value("byte_count", exp_bytes, byte_count);
        check_value("bad_frame_count", exp_bad, bad_frame_count);
        if (!saw_stall) begin
            fail_run("s_tready never dropped during an output stall");
        end else if (!saw_full) begin
            fail_run("the FIFO count never reached its depth");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: axis_buffered_path.f
src/axis_types_pkg.sv
src/fifo_cfg_pkg.sv
src/axis_skid_buffer.sv
src/axis_srl_fifo.sv
src/axis_frame_monitor.sv
src/axis_buffered_path.sv
test/axis_buffered_path_checker.sv
test/axis_buffered_path_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module axis_buffered_path_tb \
    -f axis_buffered_path.f &&
./obj_dir/Vaxis_buffered_path_tb | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
